/* bus_consts.svh */
`ifndef BUS_CONSTS_SVH
`define BUS_CONSTS_SVH

// Scratch banks behind the shared bus, one chip select each
`define BANK_COUNT 4

// Words per bank as a power of two
`define BANK_WORDS_LOG2 10

// Bus data width in bits
`define DATA_W 32

// Address bits 31:28 that select scratch memory
`define SCRATCH_REGION 4'h0

`endif

/* bus_controller.sv */
`timescale 1ns/1ns

`include "bus_consts.svh"

module bus_controller
  import bus_pkg::*;
(
  input  logic                   clock,
  input  logic                   reset,
  input  bus_addr_t              cpu_address,
  input  logic                   cpu_read,
  input  logic                   cpu_write,
  input  logic [`DATA_W-1:0]     cpu_writedata,
  input  logic [`DATA_W/8-1:0]   cpu_be,
  output logic [`DATA_W-1:0]     cpu_readdata,
  output logic                   cpu_wait,
  input  bus_addr_t              vga_address,
  input  logic                   vga_read,
  output logic [`DATA_W-1:0]     vga_readdata,
  output logic                   vga_wait,
  slave_bus_if.master            sbus,
  output chip_sel_t              chip_sel,
  input  logic [`DATA_W-1:0]     read_word
);

  localparam logic [1:0] ST_IDLE   = 2'd0;
  localparam logic [1:0] ST_ACCESS = 2'd1;
  localparam logic [1:0] ST_RETURN = 2'd2;

  logic [1:0] state;
  logic gnt_vga;
  logic cpu_req;
  logic vga_req;
  logic take;
  logic take_vga;
  logic done;

  bus_addr_t addr_q;
  logic [`DATA_W-1:0] wdata_q;
  logic [`DATA_W/8-1:0] be_q;
  logic write_q;

  assign cpu_req = cpu_read | cpu_write;
  assign vga_req = vga_read;
  assign done = (state == ST_RETURN);

  // Display wins from idle; on completion the other master goes next
  always_comb begin
    take = 1'b0;
    take_vga = 1'b0;
    if (state == ST_IDLE) begin
      take = vga_req | cpu_req;
      take_vga = vga_req;
    end else if (state == ST_RETURN) begin
      take = gnt_vga ? cpu_req : vga_req;
      take_vga = ~gnt_vga;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      state <= ST_IDLE;
      gnt_vga <= 1'b0;
    end else if (take) begin
      state <= ST_ACCESS;
      gnt_vga <= take_vga;
    end else begin
      case (state)
        ST_ACCESS: state <= ST_RETURN;
        default:   state <= ST_IDLE;
      endcase
    end
  end

  // Request capture at grant
  always_ff @(posedge clock) begin
    if (take) begin
      addr_q.raw <= take_vga ? vga_address.raw : cpu_address.raw;
      wdata_q <= cpu_writedata;
      be_q <= take_vga ? '1 : cpu_be;
      write_q <= ~take_vga & cpu_write;
    end
  end

  assign sbus.strobe = (state == ST_ACCESS);
  assign sbus.write = write_q;
  assign sbus.word = addr_q.f.word;
  assign sbus.be = be_q;
  assign sbus.writedata = wdata_q;

  // Outside the scratch region nothing is selected
  always_comb begin
    chip_sel = '0;
    if (sbus.strobe && addr_q.f.region == `SCRATCH_REGION) begin
      chip_sel[addr_q.f.bank] = 1'b1;
    end
  end

  assign cpu_wait = cpu_req & ~(done & ~gnt_vga);
  assign vga_wait = vga_req & ~(done & gnt_vga);

  assign cpu_readdata = (done && !gnt_vga) ? read_word : '0;
  assign vga_readdata = (done && gnt_vga) ? read_word : '0;

  a_cpu_held: assert property (
    @(posedge clock) disable iff (reset)
    cpu_req && cpu_wait |=> cpu_req && $stable(cpu_address.raw)
  );

  a_vga_held: assert property (
    @(posedge clock) disable iff (reset)
    vga_req && vga_wait |=> vga_req && $stable(vga_address.raw)
  );

  a_cpu_rw_exclusive: assert property (
    @(posedge clock) disable iff (reset) !(cpu_read && cpu_write)
  );

endmodule

/* bus_pkg.sv */
`include "bus_consts.svh"

package bus_pkg;

  // Byte address as masters present it, or split into decode fields
  typedef union packed {
    logic [31:0] raw;
    struct packed {
      // Top nibble picks the memory region
      logic [3:0] region;
      logic [31 - 4 - $clog2(`BANK_COUNT) - `BANK_WORDS_LOG2 - 2:0] reserved;
      logic [$clog2(`BANK_COUNT)-1:0] bank;
      logic [`BANK_WORDS_LOG2-1:0] word;
      // Byte lane, unused by word accesses
      logic [1:0] offset;
    } f;
  } bus_addr_t;

  // One-hot bank select, zero when unmapped
  typedef logic [`BANK_COUNT-1:0] chip_sel_t;

endpackage

/* read_return_mux.sv */
`timescale 1ns/1ns

`include "bus_consts.svh"

module read_return_mux
  import bus_pkg::*;
(
  input  logic               clock,
  input  logic               reset,
  slave_bus_if.slave         sbus,
  input  chip_sel_t          chip_sel,
  input  logic [`DATA_W-1:0] bank_q [`BANK_COUNT],
  output logic [`DATA_W-1:0] read_word
);

  chip_sel_t sel_q;

  // Select delayed one cycle to match the bank read register
  always_ff @(posedge clock) begin
    if (reset) begin
      sel_q <= '0;
    end else if (sbus.strobe && !sbus.write) begin
      sel_q <= chip_sel;
    end else begin
      sel_q <= '0;
    end
  end

  // Unselected banks contribute zero
  always_comb begin
    read_word = '0;
    for (int i = 0; i < `BANK_COUNT; i++) begin
      read_word = read_word | (sel_q[i] ? bank_q[i] : '0);
    end
  end

  a_sel_q_onehot: assert property (
    @(posedge clock) disable iff (reset) $onehot0(sel_q)
  );

endmodule

/* scratch_bank.sv */
`timescale 1ns/1ns

`include "bus_consts.svh"

module scratch_bank (
  input  logic               clock,
  input  logic               sel,
  slave_bus_if.slave         sbus,
  output logic [`DATA_W-1:0] q
);

  localparam int DEPTH = 2 ** `BANK_WORDS_LOG2;
  localparam int LANES = `DATA_W / 8;

  logic [`DATA_W-1:0] mem [DEPTH];
  logic access;

  assign access = sbus.strobe & sel;

  // Byte lanes written only where enabled
  always_ff @(posedge clock) begin
    if (access && sbus.write) begin
      for (int i = 0; i < LANES; i++) begin
        if (sbus.be[i]) begin
          mem[sbus.word][8*i +: 8] <= sbus.writedata[8*i +: 8];
        end
      end
    end
  end

  // Read word held until the next read of this bank
  always_ff @(posedge clock) begin
    if (access && !sbus.write) begin
      q <= mem[sbus.word];
    end
  end

  a_word_known: assert property (
    @(posedge clock) access |-> !$isunknown(sbus.word)
  );

endmodule

/* slave_bus_if.sv */
`timescale 1ns/1ns

`include "bus_consts.svh"

interface slave_bus_if;

  // Access strobe, high for the one cycle a bank is addressed
  logic strobe;
  logic write;
  logic [`BANK_WORDS_LOG2-1:0] word;
  logic [`DATA_W/8-1:0] be;
  logic [`DATA_W-1:0] writedata;

  modport master (
    output strobe,
    output write,
    output word,
    output be,
    output writedata
  );

  modport slave (
    input strobe,
    input write,
    input word,
    input be,
    input writedata
  );

endinterface

/* sys_bus.f */
+incdir+.
bus_pkg.sv
slave_bus_if.sv
bus_controller.sv
scratch_bank.sv
read_return_mux.sv
sys_bus.sv
tb_sys_bus.sv

/* sys_bus.sv */
`timescale 1ns/1ns

`include "bus_consts.svh"

module sys_bus
  import bus_pkg::*;
(
  input  logic                 clock,
  input  logic                 reset,
  input  logic [31:0]          cpu_address,
  input  logic                 cpu_read,
  input  logic                 cpu_write,
  input  logic [`DATA_W-1:0]   cpu_writedata,
  input  logic [`DATA_W/8-1:0] cpu_be,
  output logic [`DATA_W-1:0]   cpu_readdata,
  output logic                 cpu_wait,
  input  logic [31:0]          vga_address,
  input  logic                 vga_read,
  output logic [`DATA_W-1:0]   vga_readdata,
  output logic                 vga_wait
);

  slave_bus_if sbus ();

  chip_sel_t chip_sel;
  logic [`DATA_W-1:0] bank_q [`BANK_COUNT];
  logic [`DATA_W-1:0] read_word;

  bus_controller u_bus_controller (
    .clock         (clock),
    .reset         (reset),
    .cpu_address   (cpu_address),
    .cpu_read      (cpu_read),
    .cpu_write     (cpu_write),
    .cpu_writedata (cpu_writedata),
    .cpu_be        (cpu_be),
    .cpu_readdata  (cpu_readdata),
    .cpu_wait      (cpu_wait),
    .vga_address   (vga_address),
    .vga_read      (vga_read),
    .vga_readdata  (vga_readdata),
    .vga_wait      (vga_wait),
    .sbus          (sbus.master),
    .chip_sel      (chip_sel),
    .read_word     (read_word)
  );

  // One scratch RAM per chip select
  for (genvar i = 0; i < `BANK_COUNT; i++) begin : g_bank
    scratch_bank u_scratch_bank (
      .clock (clock),
      .sel   (chip_sel[i]),
      .sbus  (sbus.slave),
      .q     (bank_q[i])
    );
  end

  read_return_mux u_read_return_mux (
    .clock     (clock),
    .reset     (reset),
    .sbus      (sbus.slave),
    .chip_sel  (chip_sel),
    .bank_q    (bank_q),
    .read_word (read_word)
  );

endmodule

/* tb_sys_bus.sv */
`timescale 1ns/1ns

`include "bus_consts.svh"

module tb_sys_bus;

  localparam int DRIVE_DELAY = 2;
  localparam int BANK_BITS = $clog2(`BANK_COUNT);
  localparam int IDX_W = `BANK_WORDS_LOG2 + BANK_BITS;
  localparam int LANES = `DATA_W / 8;
  // Preloaded window of words at the bottom of each bank
  localparam int WIN_LOG2 = 5;
  localparam int N_PRELOAD = `BANK_COUNT * (2 ** WIN_LOG2);
  localparam int N_FULL = 2;
  localparam int N_BYTE = 12;
  localparam int N_REGION = 4;
  localparam int N_ARB = 4;
  localparam int N_MIX_CPU = 200;
  localparam int N_MIX_VGA = 100;
  localparam int TOTAL_REQ = N_PRELOAD + 1 + N_FULL * 2 * `BANK_COUNT + 2 * N_BYTE
                             + 3 * N_REGION + 2 * N_ARB + N_MIX_CPU + N_MIX_VGA;
  localparam int TIMEOUT_CYCLES = TOTAL_REQ * 10 + 200;

  logic clock;
  logic reset;
  logic [31:0] cpu_address;
  logic cpu_read;
  logic cpu_write;
  logic [`DATA_W-1:0] cpu_writedata;
  logic [LANES-1:0] cpu_be;
  logic [`DATA_W-1:0] cpu_readdata;
  logic cpu_wait;
  logic [31:0] vga_address;
  logic vga_read;
  logic [`DATA_W-1:0] vga_readdata;
  logic vga_wait;

  // Shadow copy of every bank indexed by bank and word
  logic [`DATA_W-1:0] shadow [2 ** IDX_W];
  logic [31:0] lfsr_state;
  int cycle_count;
  int cpu_done_at;
  int vga_done_at;

  string name_q [$];
  logic [`DATA_W-1:0] exp_q [$];
  logic [`DATA_W-1:0] act_q [$];

  // Mixed run stimulus is drawn before both masters start
  logic mix_write [N_MIX_CPU];
  logic [31:0] mix_addr [N_MIX_CPU];
  logic [`DATA_W-1:0] mix_data [N_MIX_CPU];
  logic [LANES-1:0] mix_be [N_MIX_CPU];
  int mix_gap [N_MIX_CPU];
  logic [31:0] vga_mix_addr [N_MIX_VGA];
  int vga_mix_gap [N_MIX_VGA];

  sys_bus u_sys_bus (
    .clock         (clock),
    .reset         (reset),
    .cpu_address   (cpu_address),
    .cpu_read      (cpu_read),
    .cpu_write     (cpu_write),
    .cpu_writedata (cpu_writedata),
    .cpu_be        (cpu_be),
    .cpu_readdata  (cpu_readdata),
    .cpu_wait      (cpu_wait),
    .vga_address   (vga_address),
    .vga_read      (vga_read),
    .vga_readdata  (vga_readdata),
    .vga_wait      (vga_wait)
  );

  always #20 clock = ~clock;

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    // Galois form with taps of x^32 + x^22 + x^2 + x + 1
    if (s[0]) begin
      return (s >> 1) ^ 32'h80200003;
    end
    return s >> 1;
  endfunction

  task automatic take_bits(input int n, output logic [31:0] value);
    value = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_step(lfsr_state);
      value = {value[30:0], lfsr_state[0]};
    end
  endtask

  function automatic logic [31:0] scratch_addr(input logic [IDX_W-1:0] idx);
    return {`SCRATCH_REGION, {(26 - IDX_W){1'b0}}, idx, 2'b00};
  endfunction

  function automatic logic [`DATA_W-1:0] fill_word(input logic [IDX_W-1:0] idx);
    return 32'hc0de0000 ^ ({{(32 - IDX_W){1'b0}}, idx} * 32'h9e3779b1);
  endfunction

  // Expected read word is zero outside the scratch region
  function automatic logic [`DATA_W-1:0] ref_read(input logic [31:0] addr);
    if (addr[31:28] != `SCRATCH_REGION) begin
      return '0;
    end
    return shadow[addr[2 +: IDX_W]];
  endfunction

  task automatic model_write(input logic [31:0] addr, input logic [`DATA_W-1:0] data,
                             input logic [LANES-1:0] be);
    if (addr[31:28] == `SCRATCH_REGION) begin
      for (int i = 0; i < LANES; i++) begin
        if (be[i]) begin
          shadow[addr[2 +: IDX_W]][8*i +: 8] = data[8*i +: 8];
        end
      end
    end
  endtask

  task automatic rand_window_addr(output logic [31:0] addr);
    logic [31:0] r;
    logic [IDX_W-1:0] idx;
    take_bits(BANK_BITS + WIN_LOG2, r);
    idx = '0;
    idx[IDX_W-1 -: BANK_BITS] = r[WIN_LOG2 +: BANK_BITS];
    idx[WIN_LOG2-1:0] = r[WIN_LOG2-1:0];
    addr = scratch_addr(idx);
  endtask

  task automatic check(input string name, input logic [31:0] expected,
                       input logic [31:0] actual);
    if (actual !== expected) begin
      $display("CHECK FAILED test=%s expected=%h actual=%h", name, expected, actual);
      $display("=== FAIL ===");
      $fatal(1, "stopping at first mismatch");
    end
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(posedge clock);
      #DRIVE_DELAY;
    end
  endtask

  // Called just after a rising edge; returns just after the edge ending completion
  task automatic cpu_access(input string name, input logic write, input logic [31:0] addr,
                            input logic [`DATA_W-1:0] data, input logic [LANES-1:0] be,
                            output int cycles);
    logic done;
    cpu_address = addr;
    cpu_read = ~write;
    cpu_write = write;
    cpu_writedata = data;
    cpu_be = be;
    cycles = 0;
    done = 1'b0;
    while (!done) begin
      @(negedge clock);
      cycles++;
      done = ~cpu_wait;
    end
    cpu_done_at = cycle_count;
    if (write) begin
      model_write(addr, data, be);
    end else begin
      name_q.push_back(name);
      exp_q.push_back(ref_read(addr));
      act_q.push_back(cpu_readdata);
    end
    @(posedge clock);
    #DRIVE_DELAY;
    cpu_read = 1'b0;
    cpu_write = 1'b0;
  endtask

  task automatic vga_access(input string name, input logic [31:0] addr, output int cycles);
    logic done;
    vga_address = addr;
    vga_read = 1'b1;
    cycles = 0;
    done = 1'b0;
    while (!done) begin
      @(negedge clock);
      cycles++;
      done = ~vga_wait;
    end
    vga_done_at = cycle_count;
    name_q.push_back(name);
    exp_q.push_back(ref_read(addr));
    act_q.push_back(vga_readdata);
    @(posedge clock);
    #DRIVE_DELAY;
    vga_read = 1'b0;
  endtask

  // Uncontended CPU access takes three cycles from request to completion
  task automatic cpu_op(input string name, input logic write, input logic [31:0] addr,
                        input logic [`DATA_W-1:0] data, input logic [LANES-1:0] be);
    int cycles;
    cpu_access(name, write, addr, data, be, cycles);
    check({name, " latency"}, 3, cycles);
  endtask

  always @(posedge clock) begin
    while (exp_q.size() > 0) begin
      check(name_q.pop_front(), exp_q.pop_front(), act_q.pop_front());
    end
  end

  always @(posedge clock) begin
    cycle_count++;
    if (cycle_count > TIMEOUT_CYCLES) begin
      $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("=== FAIL ===");
      $fatal(1, "timeout");
    end
  end

  initial begin
    logic [31:0] addr;
    logic [31:0] vaddr;
    logic [31:0] data;
    logic [31:0] r;
    logic [3:0] region;
    logic [IDX_W-1:0] idx;
    int cycles_cpu;
    int cycles_vga;

    clock = 1'b0;
    reset = 1'b1;
    cpu_address = '0;
    cpu_read = 1'b0;
    cpu_write = 1'b0;
    cpu_writedata = '0;
    cpu_be = '0;
    vga_address = '0;
    vga_read = 1'b0;
    lfsr_state = 32'h1194ce9d;
    cycle_count = 0;
    cpu_done_at = 0;
    vga_done_at = 0;

    repeat (16) @(posedge clock);
    #DRIVE_DELAY;
    reset = 1'b0;
    @(negedge clock);
    check("idle cpu_wait", 0, cpu_wait);
    check("idle vga_wait", 0, vga_wait);
    @(posedge clock);
    #DRIVE_DELAY;

    for (int i = 0; i < N_PRELOAD; i++) begin
      idx = '0;
      idx[IDX_W-1 -: BANK_BITS] = i[WIN_LOG2 +: BANK_BITS];
      idx[WIN_LOG2-1:0] = i[WIN_LOG2-1:0];
      cpu_op("preload", 1'b1, scratch_addr(idx), fill_word(idx), '1);
    end
    cpu_op("first read", 1'b0, scratch_addr('0), '0, '1);

    // Same word index in every bank before reading all back
    for (int n = 0; n < N_FULL; n++) begin
      take_bits(`BANK_WORDS_LOG2, r);
      for (int b = 0; b < `BANK_COUNT; b++) begin
        idx = {b[BANK_BITS-1:0], r[`BANK_WORDS_LOG2-1:0]};
        take_bits(32, data);
        cpu_op("full write", 1'b1, scratch_addr(idx), data, '1);
      end
      for (int b = 0; b < `BANK_COUNT; b++) begin
        idx = {b[BANK_BITS-1:0], r[`BANK_WORDS_LOG2-1:0]};
        cpu_op("full readback", 1'b0, scratch_addr(idx), '0, '1);
      end
    end

    for (int n = 0; n < N_BYTE; n++) begin
      rand_window_addr(addr);
      take_bits(32, data);
      take_bits(LANES, r);
      cpu_op("byte write", 1'b1, addr, data, r[LANES-1:0]);
      cpu_op("byte readback", 1'b0, addr, '0, '1);
    end

    for (int n = 0; n < N_REGION; n++) begin
      take_bits(4, r);
      region = r[3:0];
      if (region == `SCRATCH_REGION) begin
        region = ~region;
      end
      rand_window_addr(addr);
      addr[31:28] = region;
      take_bits(32, data);
      cpu_op("unmapped write", 1'b1, addr, data, '1);
      cpu_op("unmapped read", 1'b0, addr, '0, '1);
      addr[31:28] = `SCRATCH_REGION;
      cpu_op("scratch after unmapped write", 1'b0, addr, '0, '1);
    end

    for (int n = 0; n < N_ARB; n++) begin
      rand_window_addr(addr);
      rand_window_addr(vaddr);
      fork
        cpu_access("arbitration cpu", 1'b0, addr, '0, '1, cycles_cpu);
        vga_access("arbitration vga", vaddr, cycles_vga);
      join
      check("display served first", 1, vga_done_at < cpu_done_at);
      check("display latency", 3, cycles_vga);
    end

    for (int i = 0; i < N_MIX_CPU; i++) begin
      take_bits(1, r);
      mix_write[i] = r[0];
      rand_window_addr(mix_addr[i]);
      take_bits(32, mix_data[i]);
      take_bits(LANES, r);
      mix_be[i] = r[LANES-1:0];
      take_bits(1, r);
      mix_gap[i] = r[0];
    end
    for (int i = 0; i < N_MIX_VGA; i++) begin
      rand_window_addr(vga_mix_addr[i]);
      take_bits(2, r);
      vga_mix_gap[i] = r[1:0];
    end
    fork
      begin
        for (int i = 0; i < N_MIX_CPU; i++) begin
          idle_cycles(mix_gap[i]);
          cpu_access("mixed cpu", mix_write[i], mix_addr[i], mix_data[i], mix_be[i],
                     cycles_cpu);
        end
      end
      begin
        for (int i = 0; i < N_MIX_VGA; i++) begin
          idle_cycles(vga_mix_gap[i]);
          vga_access("mixed vga", vga_mix_addr[i], cycles_vga);
        end
      end
    join

    repeat (2) @(negedge clock);
    $display("=== PASS ===");
    $finish;
  end

endmodule
